//--- logic/tx_app_pkg.sv
package tx_app_pkg;

    localparam int FLOWID_W   = 3;
    localparam int NUM_FLOWS  = 1 << FLOWID_W;
    localparam int BUF_PTR_W  = 16;
    localparam int PAY_LEN_W  = 16;
    localparam int REQ_CNT_W  = 16;
    localparam int LINE_W     = 256;
    localparam int LINE_BYTES = LINE_W / 8;
    localparam int PAD_W      = $clog2(LINE_BYTES);
    localparam int LINE_REP   = LINE_W / REQ_CNT_W;  // request counts per line.

    typedef logic [FLOWID_W-1:0]  flowid_t;
    typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
    typedef logic [PAY_LEN_W-1:0] pay_len_t;
    typedef logic [REQ_CNT_W-1:0] req_cnt_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [PAD_W-1:0]     padbytes_t;

    typedef enum logic [1:0] {BENCH, CTRL_RESP, COPY} send_cmd_e;

    typedef enum logic [0:0] {MSG_REQ, PTR_UPDATE} msg_type_e;

    typedef enum logic [2:0] {
        IDLE, RD_CNTXT, STORE, REQ, WAIT_NOTIF, WRITE, PTR_UPD
    } ctrl_state_e;

    typedef struct packed {
        flowid_t   flowid;
        send_cmd_e cmd;
    } send_q_struct;

    typedef struct packed {
        req_cnt_t curr_reqs;
        req_cnt_t total_reqs;
        pay_len_t bufsize;
        logic     should_copy;  // clear means no payload lines are written.
    } app_cntxt_struct;

    typedef struct packed {
        msg_type_e msg_type;
        flowid_t   flowid;
        pay_len_t  length;
        buf_ptr_t  tail_ptr;
    } tx_msg_struct;

    typedef struct packed {
        buf_ptr_t tail_ptr;
        pay_len_t length;
    } notif_struct;

    typedef struct packed {
        flowid_t   flowid;
        buf_ptr_t  wr_ptr;
        line_t     data;
        logic      last;
        padbytes_t padbytes;
    } wr_line_struct;

endpackage

//--- logic/tx_app_cntxt_mem.sv
`timescale 1ns/100ps

module tx_app_cntxt_mem (
    input  logic                        clk,
    input  tx_app_pkg::flowid_t         rd_flowid,
    output tx_app_pkg::app_cntxt_struct rd_data,
    input  logic                        wr_en,
    input  tx_app_pkg::flowid_t         wr_flowid,
    input  tx_app_pkg::app_cntxt_struct wr_data,
    input  logic                        cfg_wr,
    input  tx_app_pkg::flowid_t         cfg_flowid,
    input  tx_app_pkg::app_cntxt_struct cfg_data
);
    import tx_app_pkg::*;

    app_cntxt_struct mem [NUM_FLOWS];

    // read data for a flow's context lands one cycle after the address.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_flowid];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_flowid] <= wr_data;
        end
        // placed last so a configuration write to the same flow takes priority.
        if (cfg_wr) begin
            mem[cfg_flowid] <= cfg_data;
        end
    end

endmodule

//--- logic/tx_app_bytes_cnt.sv
`timescale 1ns/100ps

module tx_app_bytes_cnt (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load,
    input  tx_app_pkg::pay_len_t  load_len,
    input  logic                  decr,
    output logic                  last_wr,
    output tx_app_pkg::padbytes_t padbytes
);
    import tx_app_pkg::*;

    pay_len_t  bytes_left;
    padbytes_t len_mod;
    padbytes_t pad_calc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bytes_left <= '0;
        end else if (load) begin
            bytes_left <= load_len;
        end else if (decr) begin
            bytes_left <= bytes_left - pay_len_t'(LINE_BYTES);
        end
    end

    assign last_wr = bytes_left <= pay_len_t'(LINE_BYTES);

    // the low bits of the bytes left equal the length modulo the line size.
    assign len_mod  = bytes_left[PAD_W-1:0];
    assign pad_calc = (len_mod == '0) ? '0 : padbytes_t'(LINE_BYTES - int'(len_mod));
    assign padbytes = last_wr ? pad_calc : '0;  // only the last line is padded.

endmodule

//--- logic/tx_app_datap.sv
`timescale 1ns/100ps

module tx_app_datap (
    input  logic                        clk,
    input  logic                        arst_n,
    input  tx_app_pkg::send_q_struct    send_q_data,
    input  tx_app_pkg::app_cntxt_struct cntxt_rd,
    input  tx_app_pkg::notif_struct     notif_data,
    input  logic                        store_inputs,
    input  logic                        store_cntxt,
    input  logic                        store_notif,
    input  logic                        decr,
    input  tx_app_pkg::msg_type_e       msg_sel,
    input  logic                        last_wr,
    input  tx_app_pkg::padbytes_t       padbytes,
    output tx_app_pkg::flowid_t         rd_flowid,
    output tx_app_pkg::app_cntxt_struct cntxt_wr,
    output tx_app_pkg::pay_len_t        pay_len,
    output tx_app_pkg::tx_msg_struct    tx_msg,
    output tx_app_pkg::wr_line_struct   wr_line,
    output logic                        last_pkt,
    output logic                        should_copy
);
    import tx_app_pkg::*;

    send_q_struct    entry_q;
    app_cntxt_struct cntxt_q;
    buf_ptr_t        notif_tail_q;
    buf_ptr_t        wr_ptr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_q      <= '0;
            cntxt_q      <= '0;
            notif_tail_q <= '0;
            wr_ptr_q     <= '0;
        end else begin
            if (store_inputs) begin
                entry_q <= send_q_data;
            end
            if (store_cntxt) begin
                cntxt_q <= cntxt_rd;
            end
            if (store_notif) begin
                notif_tail_q <= notif_data.tail_ptr;
                wr_ptr_q     <= notif_data.tail_ptr;  // first line goes to the old tail.
            end else if (decr) begin
                wr_ptr_q <= wr_ptr_q + buf_ptr_t'(LINE_BYTES);
            end
        end
    end

    assign rd_flowid   = entry_q.flowid;
    assign should_copy = cntxt_q.should_copy;
    assign last_pkt    = cntxt_q.curr_reqs == (cntxt_q.total_reqs - req_cnt_t'(1));

    // a control response always fits in a single line.
    assign pay_len = (entry_q.cmd == CTRL_RESP) ? pay_len_t'(LINE_BYTES) : cntxt_q.bufsize;

    always_comb begin
        cntxt_wr           = cntxt_q;
        cntxt_wr.curr_reqs = cntxt_q.curr_reqs + req_cnt_t'(1);
    end

    always_comb begin
        tx_msg.msg_type = msg_sel;
        tx_msg.flowid   = entry_q.flowid;
        tx_msg.length   = pay_len;
        if (msg_sel == PTR_UPDATE) begin
            tx_msg.tail_ptr = notif_tail_q + buf_ptr_t'(pay_len);  // new tail after payload.
        end else begin
            tx_msg.tail_ptr = '0;
        end
    end

    always_comb begin
        wr_line.flowid = entry_q.flowid;
        wr_line.wr_ptr = wr_ptr_q;
        if (entry_q.cmd == BENCH) begin
            wr_line.data = {LINE_REP{cntxt_q.curr_reqs}};
        end else begin
            wr_line.data = line_t'(1);
        end
        wr_line.last     = last_wr;
        wr_line.padbytes = padbytes;
    end

endmodule

//--- logic/tx_app_ctrl.sv
`timescale 1ns/100ps

module tx_app_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  send_valid,
    input  logic                  notif_valid,
    input  logic                  last_wr,
    input  logic                  last_pkt,
    input  logic                  should_copy,
    output logic                  store_inputs,
    output logic                  store_cntxt,
    output logic                  store_notif,
    output logic                  cnt_load,
    output logic                  cnt_decr,
    output logic                  cntxt_wr_en,
    output logic                  msg_valid,
    output logic                  wr_valid,
    output logic                  flow_done,
    output logic                  busy,
    output tx_app_pkg::msg_type_e msg_sel
);
    import tx_app_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        notif_accept;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (send_valid) begin
                    state_next = RD_CNTXT;
                end
            end
            RD_CNTXT:   state_next = STORE;  // memory read is in flight.
            STORE:      state_next = REQ;
            REQ:        state_next = WAIT_NOTIF;
            WAIT_NOTIF: begin
                if (notif_valid) begin
                    state_next = should_copy ? WRITE : PTR_UPD;
                end
            end
            WRITE: begin
                if (last_wr) begin
                    state_next = PTR_UPD;
                end
            end
            PTR_UPD:    state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    // strobes outside IDLE are dropped because the entry is only taken here.
    assign store_inputs = (state == IDLE) && send_valid;
    assign store_cntxt  = state == STORE;

    assign notif_accept = (state == WAIT_NOTIF) && notif_valid;
    assign store_notif  = notif_accept;
    assign cnt_load     = notif_accept;

    assign wr_valid = state == WRITE;
    assign cnt_decr = state == WRITE;  // one line per cycle since there is no back-pressure.

    assign msg_valid   = (state == REQ) || (state == PTR_UPD);
    assign msg_sel     = (state == PTR_UPD) ? PTR_UPDATE : MSG_REQ;
    assign cntxt_wr_en = state == PTR_UPD;
    assign flow_done   = (state == PTR_UPD) && last_pkt;

    assign busy = state != IDLE;

endmodule

//--- logic/tx_app_engine.sv
`timescale 1ns/100ps

module tx_app_engine (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        send_valid,
    input  tx_app_pkg::send_q_struct    send_q_data,
    output logic                        busy,
    output logic                        msg_valid,
    output tx_app_pkg::tx_msg_struct    tx_msg,
    input  logic                        notif_valid,
    input  tx_app_pkg::notif_struct     notif_data,
    output logic                        wr_valid,
    output tx_app_pkg::wr_line_struct   wr_line,
    output logic                        flow_done,
    input  logic                        cfg_wr,
    input  tx_app_pkg::flowid_t         cfg_flowid,
    input  tx_app_pkg::app_cntxt_struct cfg_data
);
    import tx_app_pkg::*;

    logic            store_inputs;
    logic            store_cntxt;
    logic            store_notif;
    logic            cnt_load;
    logic            cnt_decr;
    logic            cntxt_wr_en;
    logic            last_wr;
    logic            last_pkt;
    logic            should_copy;
    msg_type_e       msg_sel;
    padbytes_t       padbytes;
    flowid_t         rd_flowid;
    app_cntxt_struct cntxt_rd;
    app_cntxt_struct cntxt_wr;
    pay_len_t        pay_len;

    tx_app_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .send_valid   (send_valid),
        .notif_valid  (notif_valid),
        .last_wr      (last_wr),
        .last_pkt     (last_pkt),
        .should_copy  (should_copy),
        .store_inputs (store_inputs),
        .store_cntxt  (store_cntxt),
        .store_notif  (store_notif),
        .cnt_load     (cnt_load),
        .cnt_decr     (cnt_decr),
        .cntxt_wr_en  (cntxt_wr_en),
        .msg_valid    (msg_valid),
        .wr_valid     (wr_valid),
        .flow_done    (flow_done),
        .busy         (busy),
        .msg_sel      (msg_sel)
    );

    tx_app_datap u_datap (
        .clk          (clk),
        .arst_n       (arst_n),
        .send_q_data  (send_q_data),
        .cntxt_rd     (cntxt_rd),
        .notif_data   (notif_data),
        .store_inputs (store_inputs),
        .store_cntxt  (store_cntxt),
        .store_notif  (store_notif),
        .decr         (cnt_decr),
        .msg_sel      (msg_sel),
        .last_wr      (last_wr),
        .padbytes     (padbytes),
        .rd_flowid    (rd_flowid),
        .cntxt_wr     (cntxt_wr),
        .pay_len      (pay_len),
        .tx_msg       (tx_msg),
        .wr_line      (wr_line),
        .last_pkt     (last_pkt),
        .should_copy  (should_copy)
    );

    tx_app_bytes_cnt u_bytes_cnt (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (cnt_load),
        .load_len (pay_len),
        .decr     (cnt_decr),
        .last_wr  (last_wr),
        .padbytes (padbytes)
    );

    // write-back goes to the same flow that was read.
    tx_app_cntxt_mem u_cntxt_mem (
        .clk        (clk),
        .rd_flowid  (rd_flowid),
        .rd_data    (cntxt_rd),
        .wr_en      (cntxt_wr_en),
        .wr_flowid  (rd_flowid),
        .wr_data    (cntxt_wr),
        .cfg_wr     (cfg_wr),
        .cfg_flowid (cfg_flowid),
        .cfg_data   (cfg_data)
    );

endmodule

//--- testbench/tx_app_engine_chk.sv
`timescale 1ns/100ps

module tx_app_engine_chk (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        send_valid,
    input tx_app_pkg::send_q_struct    send_q_data,
    input logic                        busy,
    input logic                        msg_valid,
    input tx_app_pkg::tx_msg_struct    tx_msg,
    input logic                        notif_valid,
    input tx_app_pkg::notif_struct     notif_data,
    input logic                        wr_valid,
    input tx_app_pkg::wr_line_struct   wr_line,
    input logic                        flow_done,
    input logic                        cfg_wr,
    input tx_app_pkg::flowid_t         cfg_flowid,
    input tx_app_pkg::app_cntxt_struct cfg_data
);
    import tx_app_pkg::*;

    app_cntxt_struct cntxt_model [NUM_FLOWS];
    app_cntxt_struct exp_cntxt;
    send_q_struct    exp_entry;
    buf_ptr_t        exp_tail;
    pay_len_t        exp_len;
    padbytes_t       exp_pad;
    line_t           exp_data;
    logic            wait_notif;
    logic            ptr_upd;
    int              exp_lines;
    int              line_idx;
    int              fail_cnt = 0;

    task automatic flag_fail(input string what);
        fail_cnt++;
        $error("** Error %0t: %s", $time, what);
    endtask

    assign ptr_upd   = msg_valid && (tx_msg.msg_type == PTR_UPDATE);
    assign exp_len   = (exp_entry.cmd == CTRL_RESP) ? pay_len_t'(LINE_BYTES) : exp_cntxt.bufsize;
    assign exp_lines = exp_cntxt.should_copy ? (int'(exp_len) + LINE_BYTES - 1) / LINE_BYTES : 0;
    assign exp_pad   = padbytes_t'((LINE_BYTES - int'(exp_len) % LINE_BYTES) % LINE_BYTES);

    always_comb begin
        exp_data = line_t'(1);
        if (exp_entry.cmd == BENCH) begin
            for (int i = 0; i < LINE_W / REQ_CNT_W; i++) begin
                exp_data[i*REQ_CNT_W +: REQ_CNT_W] = exp_cntxt.curr_reqs;
            end
        end
    end

    // the model follows configuration writes and every finished request.
    always_ff @(posedge clk) begin
        if (ptr_upd) begin
            cntxt_model[exp_entry.flowid].curr_reqs <= exp_cntxt.curr_reqs + req_cnt_t'(1);
        end
        if (cfg_wr) begin
            cntxt_model[cfg_flowid] <= cfg_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_entry  <= '0;
            exp_cntxt  <= '0;
            exp_tail   <= '0;
            wait_notif <= 1'b0;
            line_idx   <= 0;
        end else begin
            if (send_valid && !busy) begin
                exp_entry <= send_q_data;
                exp_cntxt <= cntxt_model[send_q_data.flowid];  // context as it was at the send.
            end
            if (msg_valid && (tx_msg.msg_type == MSG_REQ)) begin
                wait_notif <= 1'b1;
            end else if (notif_valid) begin
                wait_notif <= 1'b0;
            end
            if (wait_notif && notif_valid) begin
                exp_tail <= notif_data.tail_ptr;
                line_idx <= 0;
            end else if (wr_valid) begin
                line_idx <= line_idx + 1;
            end
        end
    end

    assert property (@(posedge clk) !arst_n |-> !busy && !msg_valid && !wr_valid && !flow_done)
        else flag_fail("engine outputs active during reset");

    assert property (@(posedge clk) disable iff (!arst_n)
        (send_valid && !busy) |-> ##3 (msg_valid && (tx_msg.msg_type == MSG_REQ)
            && (tx_msg.flowid == exp_entry.flowid) && (tx_msg.length == exp_len)
            && (tx_msg.tail_ptr == '0)))
        else flag_fail("MSG_REQ missing or wrong three cycles after the send strobe");

    assert property (@(posedge clk) disable iff (!arst_n)
        wr_valid |-> (wr_line.flowid == exp_entry.flowid) && (wr_line.data == exp_data)
            && (wr_line.wr_ptr == exp_tail + buf_ptr_t'(line_idx * LINE_BYTES)))
        else flag_fail("line data or write pointer wrong");

    assert property (@(posedge clk) disable iff (!arst_n)
        wr_valid |-> (wr_line.last == (line_idx == exp_lines - 1)) && (wr_line.padbytes
            == ((line_idx == exp_lines - 1) ? exp_pad : padbytes_t'(0))))
        else flag_fail("last flag or pad bytes wrong");

    // a flow without copy must reach PTR_UPDATE with no line written.
    assert property (@(posedge clk) disable iff (!arst_n)
        ptr_upd |-> (tx_msg.flowid == exp_entry.flowid) && (tx_msg.length == exp_len)
            && (tx_msg.tail_ptr == exp_tail + buf_ptr_t'(exp_len)) && (line_idx == exp_lines))
        else flag_fail("PTR_UPDATE tail or number of lines wrong");

    assert property (@(posedge clk) disable iff (!arst_n)
        (ptr_upd || flow_done) |-> ptr_upd
            && (flow_done == (exp_cntxt.curr_reqs == exp_cntxt.total_reqs - req_cnt_t'(1))))
        else flag_fail("flow_done wrong for the request count");

endmodule

bind tx_app_engine tx_app_engine_chk chk (.*);

//--- testbench/tx_app_engine_tb.sv
`timescale 1ns/100ps

module tx_app_engine_tb;
    import tx_app_pkg::*;

    localparam int NUM_REQS   = 40;
    localparam int WAIT_LIMIT = 40;

    logic            clk;
    logic            arst_n;
    logic            send_valid;
    send_q_struct    send_q_data;
    logic            busy;
    logic            msg_valid;
    tx_msg_struct    tx_msg;
    logic            notif_valid;
    notif_struct     notif_data;
    logic            wr_valid;
    wr_line_struct   wr_line;
    logic            flow_done;
    logic            cfg_wr;
    flowid_t         cfg_flowid;
    app_cntxt_struct cfg_data;
    logic [31:0]     seed = 32'hbb100572;
    int              timeout_cnt = 0;

    tx_app_engine dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned range);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 8) % range;  // low bits of the generator are weak.
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_req();
        int n = 0;
        while (!(msg_valid && (tx_msg.msg_type == MSG_REQ)) && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (!(msg_valid && (tx_msg.msg_type == MSG_REQ))) begin
            timeout_cnt++;
            $display("timeout at %0t: the engine sent no MSG_REQ", $time);
        end
    endtask

    task automatic wait_for_idle();
        int n = 0;
        while (busy && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            timeout_cnt++;
            $display("timeout at %0t: the engine stayed busy", $time);
        end
    endtask

    task automatic write_cntxt(input flowid_t flow, input app_cntxt_struct c);
        cfg_wr     = 1'b1;
        cfg_flowid = flow;
        cfg_data   = c;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    // sends one entry and then answers for the payload buffer until the engine is idle.
    task automatic run_request(input flowid_t flow, input send_cmd_e cmd);
        int       delay;
        pay_len_t req_len;
        delay       = int'(rand_below(6));
        send_valid  = 1'b1;
        send_q_data = '{flowid: flow, cmd: cmd};
        next_cycle();
        send_valid = 1'b0;
        wait_for_req();
        req_len     = tx_msg.length;
        send_valid  = rand_below(3) == 0;  // a strobe while busy must be dropped.
        send_q_data = '{flowid: flowid_t'(rand_below(NUM_FLOWS)), cmd: BENCH};
        next_cycle();
        send_valid = 1'b0;
        repeat (delay) begin
            next_cycle();
        end
        notif_valid = 1'b1;
        notif_data  = '{tail_ptr: buf_ptr_t'(rand_below(65536)), length: req_len};
        next_cycle();
        notif_valid = 1'b0;
        wait_for_idle();
    endtask

    initial begin
        app_cntxt_struct c;
        arst_n      = 1'b0;
        send_valid  = 1'b0;
        send_q_data = '0;
        notif_valid = 1'b0;
        notif_data  = '0;
        cfg_wr      = 1'b0;
        cfg_flowid  = '0;
        cfg_data    = '0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        // small request budgets so that most flows reach their last request.
        for (int f = 0; f < NUM_FLOWS; f++) begin
            c.curr_reqs   = req_cnt_t'(rand_below(4));
            c.total_reqs  = c.curr_reqs + req_cnt_t'(1 + rand_below(4));
            c.bufsize     = (f == 1) ? pay_len_t'(2 * LINE_BYTES) : pay_len_t'(1 + rand_below(200));
            c.should_copy = (f != 0) && (rand_below(4) != 0);  // flow 0 never copies.
            write_cntxt(flowid_t'(f), c);
        end
        for (int i = 0; i < NUM_REQS; i++) begin
            run_request(flowid_t'(rand_below(NUM_FLOWS)), send_cmd_e'(2'(rand_below(3))));
        end
        repeat (4) next_cycle();
        $display("assertion failures: %0d, timeouts: %0d", dut.chk.fail_cnt, timeout_cnt);
        if ((dut.chk.fail_cnt == 0) && (timeout_cnt == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tx_app_engine.f
logic/tx_app_pkg.sv
logic/tx_app_cntxt_mem.sv
logic/tx_app_bytes_cnt.sv
logic/tx_app_datap.sv
logic/tx_app_ctrl.sv
logic/tx_app_engine.sv
testbench/tx_app_engine_chk.sv
testbench/tx_app_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tx_app_engine_tb
FILELIST  ?= tx_app_engine.f
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 1000
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR ERR_LIMIT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
